//--- all.f
+incdir+include
rtl/serial_link_pkg.sv
rtl/serial_link_bridge.sv
rtl/serial_link_data_link.sv
rtl/serial_link_physical.sv
rtl/serial_link_top.sv
tests/serial_link_checker.sv
tests/serial_link_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= serial_link_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The simulation output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/serial_link_vectors.txt
# kind div count req_flit rsp_flit, flits are 31-bit hex
# kind is req, rsp, pair or rand; rand draws kind and flit from the LCG
req 4 1 2abc1234 00000000
rsp 4 1 00000000 5def5678
pair 4 1 12345678 3ffedcba
req 4 2 7fffffff 00000000
rsp 4 2 00000000 00000001
req 6 2 40005555 00000000
rsp 6 2 00000000 2aaa0f0f
pair 6 1 0123abcd 7654fedc
req 8 2 1c3e5a79 00000000
rsp 8 2 00000000 6b8d0e2f
pair 8 1 55aa33cc 0ff0c33c
rand 4 12 00000000 00000000
rand 6 8 00000000 00000000
rand 8 6 00000000 00000000

//--- tests/serial_link_tb.sv
// Loopback testbench for the serial link that runs the tests listed in the vectors file
`timescale 1ns/100ps

`include "serial_link_defs.svh"

module serial_link_tb;

  localparam int FLIT_W = `SL_FLIT_W;

  logic                       clk_i;
  logic                       rst_i;
  logic [`SL_CLK_DIV_W-1:0]   clk_div_i;
  serial_link_pkg::req_flit_t req_i;
  logic                       req_valid_i;
  serial_link_pkg::rsp_flit_t rsp_i;
  logic                       rsp_valid_i;
  serial_link_pkg::req_flit_t req_o;
  logic                       req_valid_o;
  serial_link_pkg::rsp_flit_t rsp_o;
  logic                       rsp_valid_o;
  logic                       rcv_clk;
  logic [`SL_NUM_LANES-1:0]   lanes;

  // Test list from the vectors file
  string             t_kind[$];
  int                t_div[$];
  int                t_cnt[$];
  logic [FLIT_W-1:0] t_req[$];
  logic [FLIT_W-1:0] t_rsp[$];

  // Flits still owed by the DUT with their kind (0 for a request)
  logic              exp_kind[$];
  logic [FLIT_W-1:0] exp_flit[$];

  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_ok = 0;
  logic [31:0] rng_state = 32'ha70ecc25;

  serial_link_top dut_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .clk_div_i     (clk_div_i),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .rsp_i         (rsp_i),
    .rsp_valid_i   (rsp_valid_i),
    .req_o         (req_o),
    .req_valid_o   (req_valid_o),
    .rsp_o         (rsp_o),
    .rsp_valid_o   (rsp_valid_o),
    .ddr_rcv_clk_i (rcv_clk),
    .ddr_i         (lanes),
    .ddr_rcv_clk_o (rcv_clk),
    .ddr_o         (lanes)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
    end
    $display("Timeout, run stopped after %0d cycles", cycle_cnt);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int flits_per_event(input string kind);
    return (kind == "pair") ? 2 : 1;
  endfunction

  task automatic read_tests();
    int                fd;
    int                code;
    string             kind;
    int                div;
    int                cnt;
    logic [FLIT_W-1:0] req_val;
    logic [FLIT_W-1:0] rsp_val;
    logic [8*128-1:0]  rest;
    fd = $fopen("tests/serial_link_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vectors file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        break;
      end
      if (kind.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%d %d %h %h", div, cnt, req_val, rsp_val);
        if (code != 4) begin
          $display("Malformed line in the vectors file after kind %s", kind);
          errors++;
          break;
        end
        t_kind.push_back(kind);
        t_div.push_back(div);
        t_cnt.push_back(cnt);
        t_req.push_back(req_val);
        t_rsp.push_back(rsp_val);
      end
    end
    $fclose(fd);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      tests_ok++;
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  task automatic check_idle(input int cycles);
    int err_before;
    err_before = errors;
    repeat (cycles) begin
      @(negedge clk_i);
      assert (!req_valid_o) else begin
        $display("Fail at %0t ns: req_valid_o = %b, expected 0", $time, req_valid_o);
        errors++;
      end
      assert (!rsp_valid_o) else begin
        $display("Fail at %0t ns: rsp_valid_o = %b, expected 0", $time, rsp_valid_o);
        errors++;
      end
      assert (!rcv_clk) else begin
        $display("Fail at %0t ns: ddr_rcv_clk_o = %b, expected 0", $time, rcv_clk);
        errors++;
      end
      assert (lanes == '0) else begin
        $display("Fail at %0t ns: ddr_o = %h, expected 0", $time, lanes);
        errors++;
      end
    end
    report_test("idle after reset", err_before);
  endtask

  task automatic send_event(input logic do_req, input logic do_rsp,
                            input logic [FLIT_W-1:0] req_val,
                            input logic [FLIT_W-1:0] rsp_val, output int start);
    @(negedge clk_i);
    start       = cycle_cnt;
    req_i       = req_val;
    rsp_i       = rsp_val;
    req_valid_i = do_req;
    rsp_valid_i = do_rsp;
    if (do_req) begin
      exp_kind.push_back(1'b0);
      exp_flit.push_back(req_val);
    end
    if (do_rsp) begin
      exp_kind.push_back(1'b1);
      exp_flit.push_back(rsp_val);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    rsp_valid_i = 1'b0;
  endtask

  // Waits for every owed flit and keeps the input spacing before returning
  task automatic collect_outputs(input int div, input int start, input int flits);
    int budget;
    int quiet;
    budget = flits * (`SL_SPLITS * div + 16);
    quiet  = 0;
    while ((exp_kind.size() > 0 || quiet < 4 || cycle_cnt - start < `SL_SPLITS * div + 8)
           && cycle_cnt - start < budget) begin
      @(negedge clk_i);
      if (exp_kind.size() == 0) begin
        quiet++;
      end
      if (req_valid_o) begin
        assert (exp_kind.size() > 0 && exp_kind[0] == 1'b0) else begin
          $display("Unexpected strobe on req_valid_o at %0t ns", $time);
          errors++;
        end
        if (exp_kind.size() > 0 && exp_kind[0] == 1'b0) begin
          assert (req_o == exp_flit[0]) else begin
            $display("Fail at %0t ns: req_o = %h, expected %h", $time, req_o, exp_flit[0]);
            errors++;
          end
          void'(exp_kind.pop_front());
          void'(exp_flit.pop_front());
        end
      end
      if (rsp_valid_o) begin
        assert (exp_kind.size() > 0 && exp_kind[0] == 1'b1) else begin
          $display("Unexpected strobe on rsp_valid_o at %0t ns", $time);
          errors++;
        end
        if (exp_kind.size() > 0 && exp_kind[0] == 1'b1) begin
          assert (rsp_o == exp_flit[0]) else begin
            $display("Fail at %0t ns: rsp_o = %h, expected %h", $time, rsp_o, exp_flit[0]);
            errors++;
          end
          void'(exp_kind.pop_front());
          void'(exp_flit.pop_front());
        end
      end
    end
    assert (exp_kind.size() == 0) else begin
      $display("Output strobe missing, %0d flits never arrived by %0t ns",
               exp_kind.size(), $time);
      errors++;
    end
    exp_kind.delete();
    exp_flit.delete();
  endtask

  task automatic run_test(input int idx);
    int                err_before;
    int                start;
    logic [31:0]       r;
    logic [FLIT_W-1:0] rq;
    logic [FLIT_W-1:0] rs;
    logic              do_req;
    logic              do_rsp;
    err_before = errors;
    @(negedge clk_i);
    clk_div_i = `SL_CLK_DIV_W'(t_div[idx]);
    for (int n = 0; n < t_cnt[idx]; n++) begin
      rq     = t_req[idx] + FLIT_W'(n);
      rs     = t_rsp[idx] + FLIT_W'(n);
      do_req = (t_kind[idx] == "req") || (t_kind[idx] == "pair");
      do_rsp = (t_kind[idx] == "rsp") || (t_kind[idx] == "pair");
      if (t_kind[idx] == "rand") begin
        r      = lcg_next();
        do_req = !r[31];
        do_rsp = r[31];
        r      = lcg_next();
        rq     = r[31:1];
        rs     = r[31:1];
      end
      send_event(do_req, do_rsp, rq, rs, start);
      collect_outputs(t_div[idx], start, flits_per_event(t_kind[idx]));
    end
    report_test($sformatf("%s div %0d x%0d", t_kind[idx], t_div[idx], t_cnt[idx]),
                err_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int limit;
    rst_i       = 1'b1;
    clk_div_i   = `SL_CLK_DIV_W'(4);
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_i       = '0;
    rsp_valid_i = 1'b0;
    read_tests();
    limit = 100;
    foreach (t_kind[i]) begin
      limit += t_cnt[i] * flits_per_event(t_kind[i]) * (`SL_SPLITS * t_div[i] + 16);
    end
    cycle_limit = limit;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_idle(20);
    for (int i = 0; i < t_kind.size(); i++) begin
      run_test(i);
    end
    errors += dut_i.checker_i.fail_cnt;
    $display("Done, %0d tests, %0d ok, %0d errors, %0d assertion failures",
             tests_run, tests_ok, errors, dut_i.checker_i.fail_cnt);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tests/serial_link_checker.sv
// Protocol assertions on the serial link top level, attached to it with bind
`timescale 1ns/100ps

module serial_link_checker (
  input logic clk_i,
  input logic rst_i,
  input logic req_valid_i,
  input logic rsp_valid_i,
  input logic rcv_clk_i,
  input logic tx_busy_i
);

  // Count of failed assertions
  int fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Output strobes
  ////////////////////////////////////////////////////////////////////////////

  a_one_output: assert property (@(posedge clk_i) disable iff (rst_i)
    !(req_valid_i && rsp_valid_i))
    else begin
      $error("req_valid_o and rsp_valid_o high in the same cycle");
      fail_cnt = fail_cnt + 1;
    end

  a_req_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |=> !req_valid_i)
    else begin
      $error("req_valid_o held for more than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  a_rsp_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |=> !rsp_valid_i)
    else begin
      $error("rsp_valid_o held for more than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Forwarded clock
  ////////////////////////////////////////////////////////////////////////////

  // Transmitter busy covers every cycle a word is on the wire
  a_clk_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !tx_busy_i |-> !rcv_clk_i)
    else begin
      $error("ddr_rcv_clk_o high while no word is being sent");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind serial_link_top serial_link_checker checker_i (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_valid_i (req_valid_o),
  .rsp_valid_i (rsp_valid_o),
  .rcv_clk_i   (ddr_rcv_clk_o),
  .tx_busy_i   (tx_busy)
);

//--- rtl/serial_link_top.sv
// Serial link top level, bridge, data link and physical layer in one channel
`timescale 1ns/100ps

`include "serial_link_defs.svh"

module serial_link_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`SL_CLK_DIV_W-1:0]   clk_div_i,
  input  serial_link_pkg::req_flit_t req_i,
  input  logic                       req_valid_i,
  input  serial_link_pkg::rsp_flit_t rsp_i,
  input  logic                       rsp_valid_i,
  output serial_link_pkg::req_flit_t req_o,
  output logic                       req_valid_o,
  output serial_link_pkg::rsp_flit_t rsp_o,
  output logic                       rsp_valid_o,
  input  logic                       ddr_rcv_clk_i,
  input  logic [`SL_NUM_LANES-1:0]   ddr_i,
  output logic                       ddr_rcv_clk_o,
  output logic [`SL_NUM_LANES-1:0]   ddr_o
);

  // Bridge to data link
  serial_link_pkg::payload_t  tx_payload;
  logic                       tx_valid;
  logic                       tx_busy;
  serial_link_pkg::payload_t  rx_payload;
  logic                       rx_valid;

  // Data link to phy
  serial_link_pkg::phy_data_t tx_word;
  logic                       tx_word_valid;
  logic                       tx_word_done;
  serial_link_pkg::phy_data_t rx_word;
  logic                       rx_word_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Network bridge
  ////////////////////////////////////////////////////////////////////////////

  serial_link_bridge bridge_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .rsp_i        (rsp_i),
    .rsp_valid_i  (rsp_valid_i),
    .req_o        (req_o),
    .req_valid_o  (req_valid_o),
    .rsp_o        (rsp_o),
    .rsp_valid_o  (rsp_valid_o),
    .tx_payload_o (tx_payload),
    .tx_valid_o   (tx_valid),
    .tx_busy_i    (tx_busy),
    .rx_payload_i (rx_payload),
    .rx_valid_i   (rx_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data link and physical layer
  ////////////////////////////////////////////////////////////////////////////

  serial_link_data_link data_link_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .tx_payload_i    (tx_payload),
    .tx_valid_i      (tx_valid),
    .tx_busy_o       (tx_busy),
    .tx_word_o       (tx_word),
    .tx_word_valid_o (tx_word_valid),
    .tx_word_done_i  (tx_word_done),
    .rx_word_i       (rx_word),
    .rx_word_valid_i (rx_word_valid),
    .rx_payload_o    (rx_payload),
    .rx_valid_o      (rx_valid)
  );

  serial_link_physical physical_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .clk_div_i       (clk_div_i),
    .tx_word_i       (tx_word),
    .tx_word_valid_i (tx_word_valid),
    .tx_word_done_o  (tx_word_done),
    .rx_word_o       (rx_word),
    .rx_word_valid_o (rx_word_valid),
    .ddr_rcv_clk_i   (ddr_rcv_clk_i),
    .ddr_i           (ddr_i),
    .ddr_rcv_clk_o   (ddr_rcv_clk_o),
    .ddr_o           (ddr_o)
  );

endmodule

//--- rtl/serial_link_physical.sv
// Physical layer, DDR lanes with a forwarded divided clock and an edge-sampling receiver
`timescale 1ns/100ps

`include "serial_link_defs.svh"

module serial_link_physical (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`SL_CLK_DIV_W-1:0]   clk_div_i,
  input  serial_link_pkg::phy_data_t tx_word_i,
  input  logic                       tx_word_valid_i,
  output logic                       tx_word_done_o,
  output serial_link_pkg::phy_data_t rx_word_o,
  output logic                       rx_word_valid_o,
  input  logic                       ddr_rcv_clk_i,
  input  logic [`SL_NUM_LANES-1:0]   ddr_i,
  output logic                       ddr_rcv_clk_o,
  output logic [`SL_NUM_LANES-1:0]   ddr_o
);

  localparam int LANES = `SL_NUM_LANES;

  serial_link_pkg::phy_data_t tx_word_q;
  logic                       tx_active_q;
  logic [`SL_CLK_DIV_W-1:0]   div_cnt_q;
  logic [`SL_CLK_DIV_W-1:0]   div_half;
  logic [`SL_CLK_DIV_W-1:0]   div_last;
  logic                       rcv_clk_q;
  logic                       rcv_clk_prev_q;
  logic [LANES-1:0]           ddr_q;
  logic [LANES-1:0]           rx_lo_q;
  logic                       rcv_rise;
  logic                       rcv_fall;

  ////////////////////////////////////////////////////////////////////////////
  // Transmitter
  ////////////////////////////////////////////////////////////////////////////

  assign div_half = {1'b0, clk_div_i[`SL_CLK_DIV_W-1:1]};
  assign div_last = clk_div_i - 1'b1;

  // Done on the last cycle lets the next word follow without a gap
  assign tx_word_done_o = tx_active_q && (div_cnt_q == div_last);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_active_q <= 1'b0;
      div_cnt_q   <= '0;
    end else if (tx_word_valid_i) begin
      tx_active_q <= 1'b1;
      div_cnt_q   <= '0;
    end else if (tx_word_done_o) begin
      tx_active_q <= 1'b0;
      div_cnt_q   <= '0;
    end else if (tx_active_q) begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_word_valid_i) begin
      tx_word_q <= tx_word_i;
    end
  end

  // High phase carries the low half
  assign ddr_rcv_clk_o = tx_active_q && (div_cnt_q < div_half);

  always_comb begin
    ddr_o = '0;
    if (tx_active_q) begin
      ddr_o = ddr_rcv_clk_o ? tx_word_q[LANES-1:0] : tx_word_q[2*LANES-1:LANES];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receiver
  ////////////////////////////////////////////////////////////////////////////

  // Lanes registered with the clock so both line up on the edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rcv_clk_q      <= 1'b0;
      rcv_clk_prev_q <= 1'b0;
    end else begin
      rcv_clk_q      <= ddr_rcv_clk_i;
      rcv_clk_prev_q <= rcv_clk_q;
    end
  end

  always_ff @(posedge clk_i) begin
    ddr_q <= ddr_i;
  end

  assign rcv_rise = rcv_clk_q && !rcv_clk_prev_q;
  assign rcv_fall = !rcv_clk_q && rcv_clk_prev_q;

  always_ff @(posedge clk_i) begin
    if (rcv_rise) begin
      rx_lo_q <= ddr_q;
    end
    if (rcv_fall) begin
      rx_word_o <= {ddr_q, rx_lo_q};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_word_valid_o <= 1'b0;
    end else begin
      rx_word_valid_o <= rcv_fall;
    end
  end

endmodule

//--- rtl/serial_link_data_link.sv
// Data link layer, splits payloads into phy words for transmit and reassembles them on receive
`timescale 1ns/100ps

module serial_link_data_link (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  serial_link_pkg::payload_t  tx_payload_i,
  input  logic                       tx_valid_i,
  output logic                       tx_busy_o,
  output serial_link_pkg::phy_data_t tx_word_o,
  output logic                       tx_word_valid_o,
  input  logic                       tx_word_done_i,
  input  serial_link_pkg::phy_data_t rx_word_i,
  input  logic                       rx_word_valid_i,
  output serial_link_pkg::payload_t  rx_payload_o,
  output logic                       rx_valid_o
);

  localparam int PAYLOAD_W = $bits(serial_link_pkg::payload_t);
  localparam int WORD_W    = $bits(serial_link_pkg::phy_data_t);
  localparam int SPLITS    = PAYLOAD_W / WORD_W;
  localparam int CNT_W     = $clog2(SPLITS);
  localparam logic [CNT_W-1:0] LAST_SPLIT = CNT_W'(SPLITS - 1);

  logic [PAYLOAD_W-1:0] tx_sr_q;
  logic [PAYLOAD_W-1:0] rx_asm_q;
  logic [CNT_W-1:0]     tx_cnt_q;
  logic [CNT_W-1:0]     rx_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit, least significant word first
  ////////////////////////////////////////////////////////////////////////////

  assign tx_word_o = tx_sr_q[WORD_W-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_busy_o       <= 1'b0;
      tx_word_valid_o <= 1'b0;
      tx_cnt_q        <= '0;
    end else begin
      tx_word_valid_o <= 1'b0;
      if (tx_valid_i) begin
        tx_busy_o       <= 1'b1;
        tx_word_valid_o <= 1'b1;
        tx_cnt_q        <= '0;
      end else if (tx_word_done_i) begin
        if (tx_cnt_q == LAST_SPLIT) begin
          tx_busy_o <= 1'b0;
        end else begin
          tx_cnt_q        <= tx_cnt_q + 1'b1;
          tx_word_valid_o <= 1'b1;
        end
      end
    end
  end

  // Phy keeps its own copy, so shift right away on done
  always_ff @(posedge clk_i) begin
    if (tx_valid_i) begin
      tx_sr_q <= tx_payload_i;
    end else if (tx_word_done_i) begin
      tx_sr_q <= tx_sr_q >> WORD_W;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive
  ////////////////////////////////////////////////////////////////////////////

  // New words enter at the top so the first one ends up at the bottom
  always_ff @(posedge clk_i) begin
    if (rx_word_valid_i) begin
      rx_asm_q <= {rx_word_i, rx_asm_q[PAYLOAD_W-1:WORD_W]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_cnt_q   <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= rx_word_valid_i && (rx_cnt_q == LAST_SPLIT);
      if (rx_word_valid_i) begin
        rx_cnt_q <= (rx_cnt_q == LAST_SPLIT) ? '0 : rx_cnt_q + 1'b1;
      end
    end
  end

  assign rx_payload_o = rx_asm_q;

endmodule

//--- rtl/serial_link_bridge.sv
// Bridge between the request/response flit ports and the payload stream of the data link
`timescale 1ns/100ps

module serial_link_bridge (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  serial_link_pkg::req_flit_t req_i,
  input  logic                      req_valid_i,
  input  serial_link_pkg::rsp_flit_t rsp_i,
  input  logic                      rsp_valid_i,
  output serial_link_pkg::req_flit_t req_o,
  output logic                      req_valid_o,
  output serial_link_pkg::rsp_flit_t rsp_o,
  output logic                      rsp_valid_o,
  output serial_link_pkg::payload_t tx_payload_o,
  output logic                      tx_valid_o,
  input  logic                      tx_busy_i,
  input  serial_link_pkg::payload_t rx_payload_i,
  input  logic                      rx_valid_i
);

  serial_link_pkg::req_flit_t req_pend_flit_q;
  serial_link_pkg::rsp_flit_t rsp_pend_flit_q;
  serial_link_pkg::req_flit_t req_sel;
  serial_link_pkg::rsp_flit_t rsp_sel;
  serial_link_pkg::payload_t  next_payload;
  logic                       req_pend_q;
  logic                       rsp_pend_q;
  logic                       req_avail;
  logic                       rsp_avail;
  logic                       launch_ok;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////////////////////////////////////////

  // Busy only rises the cycle after a launch, so block that cycle too
  assign launch_ok = !tx_busy_i && !tx_valid_o;
  assign req_avail = req_pend_q | req_valid_i;
  assign rsp_avail = rsp_pend_q | rsp_valid_i;
  assign req_sel   = req_valid_i ? req_i : req_pend_flit_q;
  assign rsp_sel   = rsp_valid_i ? rsp_i : rsp_pend_flit_q;

  // Request wins when both kinds are waiting
  always_comb begin
    next_payload = '0;
    if (req_avail) begin
      next_payload.hdr      = 1'b0;
      next_payload.body.req = req_sel;
    end else begin
      next_payload.hdr      = 1'b1;
      next_payload.body.rsp = rsp_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_pend_q <= 1'b0;
      rsp_pend_q <= 1'b0;
      tx_valid_o <= 1'b0;
    end else begin
      tx_valid_o <= 1'b0;
      if (launch_ok && req_avail) begin
        tx_valid_o <= 1'b1;
        req_pend_q <= 1'b0;
        rsp_pend_q <= rsp_avail;
      end else if (launch_ok && rsp_avail) begin
        tx_valid_o <= 1'b1;
        rsp_pend_q <= 1'b0;
      end else begin
        req_pend_q <= req_avail;
        rsp_pend_q <= rsp_avail;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_pend_flit_q <= req_i;
    end
    if (rsp_valid_i) begin
      rsp_pend_flit_q <= rsp_i;
    end
    if (launch_ok && (req_avail || rsp_avail)) begin
      tx_payload_o <= next_payload;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_valid_o <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      req_valid_o <= rx_valid_i && !rx_payload_i.hdr;
      rsp_valid_o <= rx_valid_i && rx_payload_i.hdr;
    end
  end

  // Header picks which view of the body is taken
  always_ff @(posedge clk_i) begin
    if (rx_valid_i && !rx_payload_i.hdr) begin
      req_o <= rx_payload_i.body.req;
    end
    if (rx_valid_i && rx_payload_i.hdr) begin
      rsp_o <= rx_payload_i.body.rsp;
    end
  end

endmodule

//--- rtl/serial_link_pkg.sv
// Flit, payload and phy word types used across the serial link layers

`include "serial_link_defs.svh"

package serial_link_pkg;

  // Network request flit
  typedef struct packed {
    logic                   we;
    logic [`SL_ADDR_W-1:0]  addr;
    logic [`SL_DATA_W-1:0]  data;
  } req_flit_t;

  // Network response flit
  typedef struct packed {
    logic                   err;
    logic [`SL_ADDR_W-1:0]  tag;
    logic [`SL_DATA_W-1:0]  data;
  } rsp_flit_t;

  // Same bits, read as request or response depending on the header
  typedef union packed {
    req_flit_t req;
    rsp_flit_t rsp;
  } payload_body_u;

  // hdr = 0 for a request, 1 for a response
  typedef struct packed {
    logic          hdr;
    payload_body_u body;
  } payload_t;

  // One beat on the wire, both clock phases
  typedef logic [2*`SL_NUM_LANES-1:0] phy_data_t;

endpackage

//--- include/serial_link_defs.svh
// Link dimensions shared by the package, the physical layer, the top level and the testbench
`ifndef SERIAL_LINK_DEFS_SVH
`define SERIAL_LINK_DEFS_SVH

// Data lanes per direction, each carries one bit per clock phase
`define SL_NUM_LANES 4

// Request address and response tag width
`define SL_ADDR_W 14

// Flit data width
`define SL_DATA_W 16

// Full flit, kind bit plus address or tag plus data
`define SL_FLIT_W 31

// Phy words per payload
`define SL_SPLITS 4

// Width of the clock divider setting
`define SL_CLK_DIV_W 4

`endif
